// File: adapter_cfg_pkg.sv
// Adapter configuration package
package adapter_cfg_pkg;

  // ------------------------------------------------------------
  // default sizes
  // ------------------------------------------------------------
  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned AxiDataWidth    = 64;
  localparam int unsigned DefaultNumBeats = 4;
  localparam int unsigned DefaultIdWidth  = 4;

  // ------------------------------------------------------------
  // payload types
  // ------------------------------------------------------------
  // byte address of a request
  typedef logic [AddrWidth-1:0] addr_t;
  // one AXI data beat and its byte enables
  typedef logic [AxiDataWidth-1:0] beat_t;
  typedef logic [AxiDataWidth/8-1:0] strb_t;

endpackage

// File: axi_proto_pkg.sv
// AXI protocol encodings
package axi_proto_pkg;

  // ------------------------------------------------------------
  // cache side request kind
  // ------------------------------------------------------------
  // a single beat or a whole cache line
  typedef enum logic {
    SINGLE_REQ = 1'b0,
    LINE_REQ   = 1'b1
  } req_kind_t;

  // ------------------------------------------------------------
  // AXI channel fields
  // ------------------------------------------------------------
  // burst type, only incrementing bursts are issued
  typedef logic [1:0] burst_t;
  localparam burst_t BURST_INCR = 2'b01;

  // response code
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY = 2'b00;

  // number of beats minus one
  typedef logic [7:0] len_t;

  // bytes per beat is 2**size
  typedef logic [2:0] size_t;

endpackage

// File: engine_if.sv
// Dispatcher to engine command link
interface engine_if #(
  parameter int unsigned IdWidth = adapter_cfg_pkg::DefaultIdWidth
);

  // one cycle strobe that hands a request to the engine
  logic                     start;

  // request fields, stable while the engine is active
  axi_proto_pkg::req_kind_t kind;
  adapter_cfg_pkg::addr_t   addr;
  axi_proto_pkg::size_t     size;
  logic [IdWidth-1:0]       id;

  // engine feedback pulses
  logic                     gnt;
  logic                     done;
  logic [IdWidth-1:0]       rsp_id;

  modport dispatch (
    output start, kind, addr, size, id,
    input  gnt, done, rsp_id
  );

  modport engine (
    input  start, kind, addr, size, id,
    output gnt, done, rsp_id
  );

endinterface

// File: adapter_dispatch.sv
// Request dispatcher
module adapter_dispatch #(
  parameter int unsigned IdWidth = adapter_cfg_pkg::DefaultIdWidth
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic                     we_i,
  input  axi_proto_pkg::req_kind_t kind_i,
  input  adapter_cfg_pkg::addr_t   addr_i,
  input  axi_proto_pkg::size_t     size_i,
  input  logic [IdWidth-1:0]       id_i,
  output logic                     gnt_o,
  output logic                     valid_o,
  output logic [IdWidth-1:0]       id_o,
  output logic                     busy_o,
  engine_if.dispatch               wr_cmd,
  engine_if.dispatch               rd_cmd
);

  logic                     active_q;
  logic                     start_q;
  logic                     sel_wr_q;
  logic                     accept;
  logic                     finish;
  axi_proto_pkg::req_kind_t kind_q;
  adapter_cfg_pkg::addr_t   addr_q;
  axi_proto_pkg::size_t     size_q;
  logic [IdWidth-1:0]       id_q;

  // a new request is only taken while idle
  assign accept = req_i & ~active_q;
  assign finish = wr_cmd.done | rd_cmd.done;

  // ------------------------------------------------------------
  // idle / active control
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      start_q  <= 1'b0;
      sel_wr_q <= 1'b0;
    end else begin
      start_q <= accept;
      if (accept) begin
        active_q <= 1'b1;
        sel_wr_q <= we_i;
      end else if (finish) begin
        active_q <= 1'b0;
      end
    end
  end

  // command fields, captured once per request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      kind_q <= kind_i;
      addr_q <= addr_i;
      size_q <= size_i;
      id_q   <= id_i;
    end
  end

  // ------------------------------------------------------------
  // engine commands and merged responses
  // ------------------------------------------------------------
  assign wr_cmd.start = start_q & sel_wr_q;
  assign wr_cmd.kind  = kind_q;
  assign wr_cmd.addr  = addr_q;
  assign wr_cmd.size  = size_q;
  assign wr_cmd.id    = id_q;

  assign rd_cmd.start = start_q & ~sel_wr_q;
  assign rd_cmd.kind  = kind_q;
  assign rd_cmd.addr  = addr_q;
  assign rd_cmd.size  = size_q;
  assign rd_cmd.id    = id_q;

  assign gnt_o   = wr_cmd.gnt | rd_cmd.gnt;
  assign valid_o = finish;
  assign id_o    = sel_wr_q ? wr_cmd.rsp_id : rd_cmd.rsp_id;
  assign busy_o  = active_q;

endmodule

// File: axi_write_ctrl.sv
// AXI write channel engine
module axi_write_ctrl #(
  parameter int unsigned NumBeats = adapter_cfg_pkg::DefaultNumBeats,
  parameter int unsigned IdWidth  = adapter_cfg_pkg::DefaultIdWidth
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  engine_if.engine                              cmd,
  input  adapter_cfg_pkg::beat_t [NumBeats-1:0] wdata_i,
  input  adapter_cfg_pkg::strb_t [NumBeats-1:0] be_i,
  input  logic                                  aw_ready_i,
  input  logic                                  w_ready_i,
  input  logic                                  b_valid_i,
  input  logic [IdWidth-1:0]                    b_id_i,
  output logic                                  aw_valid_o,
  output adapter_cfg_pkg::addr_t                aw_addr_o,
  output axi_proto_pkg::len_t                   aw_len_o,
  output axi_proto_pkg::size_t                  aw_size_o,
  output axi_proto_pkg::burst_t                 aw_burst_o,
  output logic [IdWidth-1:0]                    aw_id_o,
  output logic                                  w_valid_o,
  output adapter_cfg_pkg::beat_t                w_data_o,
  output adapter_cfg_pkg::strb_t                w_strb_o,
  output logic                                  w_last_o,
  output logic                                  b_ready_o
);

  localparam int unsigned BeatIdxW = $clog2(NumBeats);
  localparam logic [BeatIdxW-1:0] LastBeat = BeatIdxW'(NumBeats - 1);
  localparam axi_proto_pkg::size_t BeatSize =
      axi_proto_pkg::size_t'($clog2(adapter_cfg_pkg::AxiDataWidth / 8));

  logic                is_line;
  logic                active_q;
  logic                aw_done_q;
  logic                w_done_q;
  logic [BeatIdxW-1:0] w_cnt_q;
  logic [BeatIdxW-1:0] beat_idx;
  logic                aw_fire;
  logic                w_fire;
  logic                w_last_fire;

  assign is_line = (cmd.kind == axi_proto_pkg::LINE_REQ);

  // ------------------------------------------------------------
  // AW channel
  // ------------------------------------------------------------
  assign aw_valid_o = active_q & ~aw_done_q;
  assign aw_addr_o  = cmd.addr;
  assign aw_len_o   = is_line ? axi_proto_pkg::len_t'(NumBeats - 1) : '0;
  assign aw_size_o  = is_line ? BeatSize : cmd.size;
  assign aw_burst_o = axi_proto_pkg::BURST_INCR;
  assign aw_id_o    = cmd.id;

  // ------------------------------------------------------------
  // W channel
  // ------------------------------------------------------------
  // single writes always take beat 0 of the line
  assign beat_idx  = is_line ? w_cnt_q : '0;
  assign w_valid_o = active_q & ~w_done_q;
  assign w_data_o  = wdata_i[beat_idx];
  assign w_strb_o  = be_i[beat_idx];
  assign w_last_o  = ~is_line | (w_cnt_q == LastBeat);

  assign aw_fire     = aw_valid_o & aw_ready_i;
  assign w_fire      = w_valid_o & w_ready_i;
  assign w_last_fire = w_fire & w_last_o;

  // grant once both address and all data have gone out
  assign cmd.gnt = active_q & ~(aw_done_q & w_done_q)
                 & (aw_done_q | aw_fire) & (w_done_q | w_last_fire);

  // B phase starts after both AW and the last W are accepted
  assign b_ready_o  = active_q & aw_done_q & w_done_q;
  assign cmd.done   = b_ready_o & b_valid_i;
  assign cmd.rsp_id = b_id_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q  <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      w_cnt_q   <= '0;
    end else if (cmd.start) begin
      active_q  <= 1'b1;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      w_cnt_q   <= '0;
    end else begin
      if (aw_fire) aw_done_q <= 1'b1;
      if (w_fire) w_cnt_q <= w_cnt_q + 1'b1;
      if (w_last_fire) w_done_q <= 1'b1;
      if (cmd.done) active_q <= 1'b0;
    end
  end

endmodule

// File: axi_read_ctrl.sv
// AXI read channel engine
module axi_read_ctrl #(
  parameter int unsigned NumBeats = adapter_cfg_pkg::DefaultNumBeats,
  parameter int unsigned IdWidth  = adapter_cfg_pkg::DefaultIdWidth
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  engine_if.engine                              cmd,
  input  logic                                  ar_ready_i,
  input  logic                                  r_valid_i,
  input  adapter_cfg_pkg::beat_t                r_data_i,
  input  logic [IdWidth-1:0]                    r_id_i,
  input  logic                                  r_last_i,
  output logic                                  ar_valid_o,
  output adapter_cfg_pkg::addr_t                ar_addr_o,
  output axi_proto_pkg::len_t                   ar_len_o,
  output axi_proto_pkg::size_t                  ar_size_o,
  output axi_proto_pkg::burst_t                 ar_burst_o,
  output logic [IdWidth-1:0]                    ar_id_o,
  output logic                                  r_ready_o,
  output adapter_cfg_pkg::beat_t [NumBeats-1:0] rdata_o,
  output adapter_cfg_pkg::beat_t                critical_word_o,
  output logic                                  critical_word_valid_o
);

  localparam int unsigned BeatIdxW = $clog2(NumBeats);
  localparam int unsigned ByteOffW = $clog2(adapter_cfg_pkg::AxiDataWidth / 8);
  localparam int unsigned LineOffW = BeatIdxW + ByteOffW;
  localparam adapter_cfg_pkg::addr_t LineMask =
      ~adapter_cfg_pkg::addr_t'((2 ** LineOffW) - 1);
  localparam axi_proto_pkg::size_t BeatSize = axi_proto_pkg::size_t'(ByteOffW);

  logic                                  is_line;
  logic                                  active_q;
  logic                                  ar_done_q;
  logic                                  fin_q;
  logic [BeatIdxW-1:0]                   beat_cnt_q;
  logic [BeatIdxW-1:0]                   crit_off_q;
  logic [IdWidth-1:0]                    id_q;
  adapter_cfg_pkg::beat_t [NumBeats-1:0] line_q;
  logic                                  ar_fire;
  logic                                  r_fire;

  assign is_line = (cmd.kind == axi_proto_pkg::LINE_REQ);

  // ------------------------------------------------------------
  // AR channel
  // ------------------------------------------------------------
  // line reads start at the line base
  assign ar_valid_o = active_q & ~ar_done_q;
  assign ar_addr_o  = is_line ? (cmd.addr & LineMask) : cmd.addr;
  assign ar_len_o   = is_line ? axi_proto_pkg::len_t'(NumBeats - 1) : '0;
  assign ar_size_o  = is_line ? BeatSize : cmd.size;
  assign ar_burst_o = axi_proto_pkg::BURST_INCR;
  assign ar_id_o    = cmd.id;

  assign ar_fire = ar_valid_o & ar_ready_i;
  assign cmd.gnt = ar_fire;

  // ------------------------------------------------------------
  // R channel
  // ------------------------------------------------------------
  assign r_ready_o = active_q & ar_done_q & ~fin_q;
  assign r_fire    = r_valid_i & r_ready_o;

  // the beat the request address points at
  assign critical_word_valid_o = r_fire & is_line & (beat_cnt_q == crit_off_q);
  assign critical_word_o       = r_data_i;

  assign rdata_o    = line_q;
  assign cmd.done   = fin_q;
  assign cmd.rsp_id = id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= 1'b0;
      ar_done_q  <= 1'b0;
      fin_q      <= 1'b0;
      beat_cnt_q <= '0;
    end else if (cmd.start) begin
      active_q   <= 1'b1;
      ar_done_q  <= 1'b0;
      fin_q      <= 1'b0;
      beat_cnt_q <= '0;
    end else begin
      if (ar_fire) ar_done_q <= 1'b1;
      if (r_fire) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        if (r_last_i) fin_q <= 1'b1;
      end
      // completion is reported one cycle after the last beat
      if (fin_q) begin
        fin_q    <= 1'b0;
        active_q <= 1'b0;
      end
    end
  end

  // line buffer and captured fields
  always_ff @(posedge clk_i) begin
    if (cmd.start) begin
      crit_off_q <= cmd.addr[LineOffW-1:ByteOffW];
    end
    if (r_fire) begin
      line_q[is_line ? beat_cnt_q : '0] <= r_data_i;
      if (r_last_i) id_q <= r_id_i;
    end
  end

endmodule

// File: axi_adapter.sv
// Cache to AXI4 adapter
module axi_adapter #(
  parameter int unsigned NumBeats = adapter_cfg_pkg::DefaultNumBeats,
  parameter int unsigned IdWidth  = adapter_cfg_pkg::DefaultIdWidth
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // ------------------------------------------------------------
  // cache side
  // ------------------------------------------------------------
  input  logic                                  req_i,
  input  axi_proto_pkg::req_kind_t              kind_i,
  input  adapter_cfg_pkg::addr_t                addr_i,
  input  logic                                  we_i,
  input  axi_proto_pkg::size_t                  size_i,
  input  logic [IdWidth-1:0]                    id_i,
  input  adapter_cfg_pkg::beat_t [NumBeats-1:0] wdata_i,
  input  adapter_cfg_pkg::strb_t [NumBeats-1:0] be_i,
  output logic                                  gnt_o,
  output logic                                  valid_o,
  output adapter_cfg_pkg::beat_t [NumBeats-1:0] rdata_o,
  output logic [IdWidth-1:0]                    id_o,
  output adapter_cfg_pkg::beat_t                critical_word_o,
  output logic                                  critical_word_valid_o,
  output logic                                  busy_o,
  // ------------------------------------------------------------
  // AXI master
  // ------------------------------------------------------------
  output logic                                  aw_valid_o,
  input  logic                                  aw_ready_i,
  output adapter_cfg_pkg::addr_t                aw_addr_o,
  output axi_proto_pkg::len_t                   aw_len_o,
  output axi_proto_pkg::size_t                  aw_size_o,
  output axi_proto_pkg::burst_t                 aw_burst_o,
  output logic [IdWidth-1:0]                    aw_id_o,
  output logic                                  w_valid_o,
  input  logic                                  w_ready_i,
  output adapter_cfg_pkg::beat_t                w_data_o,
  output adapter_cfg_pkg::strb_t                w_strb_o,
  output logic                                  w_last_o,
  input  logic                                  b_valid_i,
  output logic                                  b_ready_o,
  input  logic [IdWidth-1:0]                    b_id_i,
  output logic                                  ar_valid_o,
  input  logic                                  ar_ready_i,
  output adapter_cfg_pkg::addr_t                ar_addr_o,
  output axi_proto_pkg::len_t                   ar_len_o,
  output axi_proto_pkg::size_t                  ar_size_o,
  output axi_proto_pkg::burst_t                 ar_burst_o,
  output logic [IdWidth-1:0]                    ar_id_o,
  input  logic                                  r_valid_i,
  output logic                                  r_ready_o,
  input  adapter_cfg_pkg::beat_t                r_data_i,
  input  logic [IdWidth-1:0]                    r_id_i,
  input  logic                                  r_last_i
);

  engine_if #(.IdWidth(IdWidth)) wr_cmd ();
  engine_if #(.IdWidth(IdWidth)) rd_cmd ();

  adapter_dispatch #(
    .IdWidth (IdWidth)
  ) dispatch_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .we_i    (we_i),
    .kind_i  (kind_i),
    .addr_i  (addr_i),
    .size_i  (size_i),
    .id_i    (id_i),
    .gnt_o   (gnt_o),
    .valid_o (valid_o),
    .id_o    (id_o),
    .busy_o  (busy_o),
    .wr_cmd  (wr_cmd.dispatch),
    .rd_cmd  (rd_cmd.dispatch)
  );

  axi_write_ctrl #(
    .NumBeats (NumBeats),
    .IdWidth  (IdWidth)
  ) write_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cmd        (wr_cmd.engine),
    .wdata_i    (wdata_i),
    .be_i       (be_i),
    .aw_ready_i (aw_ready_i),
    .w_ready_i  (w_ready_i),
    .b_valid_i  (b_valid_i),
    .b_id_i     (b_id_i),
    .aw_valid_o (aw_valid_o),
    .aw_addr_o  (aw_addr_o),
    .aw_len_o   (aw_len_o),
    .aw_size_o  (aw_size_o),
    .aw_burst_o (aw_burst_o),
    .aw_id_o    (aw_id_o),
    .w_valid_o  (w_valid_o),
    .w_data_o   (w_data_o),
    .w_strb_o   (w_strb_o),
    .w_last_o   (w_last_o),
    .b_ready_o  (b_ready_o)
  );

  axi_read_ctrl #(
    .NumBeats (NumBeats),
    .IdWidth  (IdWidth)
  ) read_i (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .cmd                   (rd_cmd.engine),
    .ar_ready_i            (ar_ready_i),
    .r_valid_i             (r_valid_i),
    .r_data_i              (r_data_i),
    .r_id_i                (r_id_i),
    .r_last_i              (r_last_i),
    .ar_valid_o            (ar_valid_o),
    .ar_addr_o             (ar_addr_o),
    .ar_len_o              (ar_len_o),
    .ar_size_o             (ar_size_o),
    .ar_burst_o            (ar_burst_o),
    .ar_id_o               (ar_id_o),
    .r_ready_o             (r_ready_o),
    .rdata_o               (rdata_o),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o)
  );

endmodule

// File: tb_axi_adapter.sv
// AXI adapter testbench
module tb_axi_adapter;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumBeats = 4;
  localparam int unsigned IdWidth  = 4;
  localparam int unsigned MaxCycles = 20000;
  localparam logic [31:0] LfsrTaps = 32'h80200003;

  typedef adapter_cfg_pkg::beat_t [NumBeats-1:0] line_t;
  typedef adapter_cfg_pkg::strb_t [NumBeats-1:0] line_be_t;
  typedef logic [IdWidth-1:0] id_t;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     req_i;
  axi_proto_pkg::req_kind_t kind_i;
  adapter_cfg_pkg::addr_t   addr_i;
  logic                     we_i;
  axi_proto_pkg::size_t     size_i;
  id_t                      id_i;
  line_t                    wdata_i;
  line_be_t                 be_i;
  logic                     gnt_o;
  logic                     valid_o;
  line_t                    rdata_o;
  id_t                      id_o;
  adapter_cfg_pkg::beat_t   critical_word_o;
  logic                     critical_word_valid_o;
  logic                     busy_o;
  logic                     aw_valid_o;
  logic                     aw_ready_i;
  adapter_cfg_pkg::addr_t   aw_addr_o;
  axi_proto_pkg::len_t      aw_len_o;
  axi_proto_pkg::size_t     aw_size_o;
  axi_proto_pkg::burst_t    aw_burst_o;
  id_t                      aw_id_o;
  logic                     w_valid_o;
  logic                     w_ready_i;
  adapter_cfg_pkg::beat_t   w_data_o;
  adapter_cfg_pkg::strb_t   w_strb_o;
  logic                     w_last_o;
  logic                     b_valid_i;
  logic                     b_ready_o;
  id_t                      b_id_i;
  logic                     ar_valid_o;
  logic                     ar_ready_i;
  adapter_cfg_pkg::addr_t   ar_addr_o;
  axi_proto_pkg::len_t      ar_len_o;
  axi_proto_pkg::size_t     ar_size_o;
  axi_proto_pkg::burst_t    ar_burst_o;
  id_t                      ar_id_o;
  logic                     r_valid_i;
  logic                     r_ready_o;
  adapter_cfg_pkg::beat_t   r_data_i;
  id_t                      r_id_i;
  logic                     r_last_i;

  // slave memory and expected model, both byte wide
  logic [7:0] slave_mem [logic [31:0]];
  logic [7:0] model_mem [logic [31:0]];
  logic [31:0] lfsr;
  int unsigned cycles;

  // current transfer, seen by the slave for field checks
  string                  cur_test;
  logic                   cur_line;
  adapter_cfg_pkg::addr_t cur_addr;

  // slave write and read state
  logic                   aw_seen;
  adapter_cfg_pkg::addr_t aw_addr_s;
  id_t                    aw_id_s;
  logic                   w_last_seen;
  adapter_cfg_pkg::beat_t w_data_q [$];
  adapter_cfg_pkg::strb_t w_strb_q [$];
  logic                   b_pend;
  logic                   b_hs;
  adapter_cfg_pkg::beat_t r_data_q [$];
  logic                   r_last_q [$];
  id_t                    r_id_s;
  logic                   r_hs;

  axi_adapter #(
    .NumBeats (NumBeats),
    .IdWidth  (IdWidth)
  ) dut_i (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("timeout: the run did not finish within %0d cycles", MaxCycles);
      fail_run();
    end
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic fail_run();
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic next_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ LfsrTaps) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], next_bit()};
    end
    return v;
  endfunction

  // untouched bytes hold a pattern of the whole address
  function automatic logic [7:0] fill_byte(logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic adapter_cfg_pkg::beat_t slave_beat(adapter_cfg_pkg::addr_t a);
    adapter_cfg_pkg::beat_t v;
    logic [31:0] ba;
    for (int b = 0; b < 8; b++) begin
      ba = (a & ~32'h7) + 32'(b);
      v[b*8 +: 8] = slave_mem.exists(ba) ? slave_mem[ba] : fill_byte(ba);
    end
    return v;
  endfunction

  function automatic adapter_cfg_pkg::beat_t model_beat(adapter_cfg_pkg::addr_t a);
    adapter_cfg_pkg::beat_t v;
    logic [31:0] ba;
    for (int b = 0; b < 8; b++) begin
      ba = (a & ~32'h7) + 32'(b);
      v[b*8 +: 8] = model_mem.exists(ba) ? model_mem[ba] : fill_byte(ba);
    end
    return v;
  endfunction

  task automatic check_beat(string name, adapter_cfg_pkg::beat_t exp,
                            adapter_cfg_pkg::beat_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_line(string name, line_t exp, line_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_id(string name, id_t exp, id_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_len(string name, axi_proto_pkg::len_t exp, axi_proto_pkg::len_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_size(string name, axi_proto_pkg::size_t exp,
                            axi_proto_pkg::size_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_burst(string name, axi_proto_pkg::burst_t exp,
                             axi_proto_pkg::burst_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_addr(string name, adapter_cfg_pkg::addr_t exp,
                            adapter_cfg_pkg::addr_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  // ------------------------------------------------------------
  // AXI slave model, everything decided on the falling edge
  // ------------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // retire beats accepted at the last rising edge
      if (b_hs) begin
        b_valid_i = 1'b0;
        b_hs = 1'b0;
      end
      if (r_hs) begin
        void'(r_data_q.pop_front());
        void'(r_last_q.pop_front());
        r_valid_i = 1'b0;
        r_hs = 1'b0;
      end
      // responses only follow address and data accepted at an earlier edge
      if (aw_seen && w_last_seen) b_pend = 1'b1;
      if (!b_valid_i && b_pend && next_bit()) begin
        b_valid_i = 1'b1;
        b_id_i = aw_id_s;
      end
      b_hs = b_valid_i && b_ready_o;
      if (b_hs) begin
        // memory takes the held write once B is sent
        for (int i = 0; i < w_data_q.size(); i++) begin
          for (int b = 0; b < 8; b++) begin
            if (w_strb_q[i][b]) begin
              slave_mem[(aw_addr_s & ~32'h7) + 32'(i * 8 + b)] = w_data_q[i][b*8 +: 8];
            end
          end
        end
        w_data_q.delete();
        w_strb_q.delete();
        aw_seen = 1'b0;
        w_last_seen = 1'b0;
        b_pend = 1'b0;
      end
      if (!r_valid_i && r_data_q.size() > 0 && next_bit()) begin
        r_valid_i = 1'b1;
        r_data_i = r_data_q[0];
        r_last_i = r_last_q[0];
        r_id_i = r_id_s;
      end
      r_hs = r_valid_i && r_ready_o;
      aw_ready_i = next_bit() | next_bit();
      w_ready_i  = next_bit() | next_bit();
      ar_ready_i = next_bit() | next_bit();
      // all requests here move full 8 byte beats
      if (aw_valid_o && aw_ready_i) begin
        check_len({cur_test, " aw len"}, cur_line ? 8'd3 : 8'd0, aw_len_o);
        check_size({cur_test, " aw size"}, 3'd3, aw_size_o);
        check_burst({cur_test, " aw burst"}, axi_proto_pkg::BURST_INCR, aw_burst_o);
        check_addr({cur_test, " aw addr"}, cur_addr, aw_addr_o);
        aw_seen = 1'b1;
        aw_addr_s = aw_addr_o;
        aw_id_s = aw_id_o;
      end
      if (w_valid_o && w_ready_i) begin
        check_bit({cur_test, " w last"},
                  !cur_line || (w_data_q.size() == NumBeats - 1), w_last_o);
        w_data_q.push_back(w_data_o);
        w_strb_q.push_back(w_strb_o);
        if (w_last_o) w_last_seen = 1'b1;
      end
      if (ar_valid_o && ar_ready_i) begin
        check_len({cur_test, " ar len"}, cur_line ? 8'd3 : 8'd0, ar_len_o);
        check_size({cur_test, " ar size"}, 3'd3, ar_size_o);
        check_burst({cur_test, " ar burst"}, axi_proto_pkg::BURST_INCR, ar_burst_o);
        check_addr({cur_test, " ar addr"}, cur_line ? (cur_addr & ~32'h1f) : cur_addr,
                   ar_addr_o);
        for (int k = 0; k <= int'(ar_len_o); k++) begin
          r_data_q.push_back(slave_beat(ar_addr_o + 32'(k * 8)));
          r_last_q.push_back(k == int'(ar_len_o));
        end
        r_id_s = ar_id_o;
      end
    end
  end

  // ------------------------------------------------------------
  // request driver
  // ------------------------------------------------------------
  task automatic run_transfer(string name, logic we, logic line,
                              adapter_cfg_pkg::addr_t addr, id_t id,
                              line_t wdata, line_be_t be, output line_t rd,
                              output int cw_cnt, output adapter_cfg_pkg::beat_t cw);
    logic got_gnt;
    logic done;
    id_t  rid;
    got_gnt = 1'b0;
    done = 1'b0;
    cw_cnt = 0;
    cw = '0;
    rd = '0;
    rid = '0;
    cur_test = name;
    cur_line = line;
    cur_addr = addr;
    @(negedge clk_i);
    req_i = 1'b1;
    we_i = we;
    kind_i = line ? axi_proto_pkg::LINE_REQ : axi_proto_pkg::SINGLE_REQ;
    addr_i = addr;
    size_i = 3'd3;
    id_i = id;
    wdata_i = wdata;
    be_i = be;
    while (!done) begin
      // sample halfway through the low phase
      #5;
      if (gnt_o) got_gnt = 1'b1;
      if (critical_word_valid_o) begin
        cw_cnt++;
        cw = critical_word_o;
      end
      if (valid_o) begin
        done = 1'b1;
        rd = rdata_o;
        rid = id_o;
      end
      @(negedge clk_i);
      if (got_gnt) req_i = 1'b0;
    end
    check_bit({name, " gnt seen"}, 1'b1, got_gnt);
    check_id({name, " id"}, id, rid);
    #5;
    check_bit({name, " busy after done"}, 1'b0, busy_o);
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic test_reset();
    check_bit("reset busy", 1'b0, busy_o);
    check_bit("reset gnt", 1'b0, gnt_o);
    check_bit("reset valid", 1'b0, valid_o);
  endtask

  task automatic test_single(string name, adapter_cfg_pkg::addr_t addr,
                             adapter_cfg_pkg::beat_t data, adapter_cfg_pkg::strb_t be);
    line_t wl;
    line_be_t bl;
    line_t rd;
    int cnt;
    adapter_cfg_pkg::beat_t cw;
    adapter_cfg_pkg::beat_t exp;
    wl = '0;
    bl = '0;
    wl[0] = data;
    bl[0] = be;
    // merge the enabled bytes into the old contents
    exp = model_beat(addr);
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        exp[b*8 +: 8] = data[b*8 +: 8];
        model_mem[(addr & ~32'h7) + 32'(b)] = data[b*8 +: 8];
      end
    end
    run_transfer({name, " write"}, 1'b1, 1'b0, addr, id_t'(rand_bits(4)), wl, bl, rd, cnt, cw);
    run_transfer({name, " read"}, 1'b0, 1'b0, addr, id_t'(rand_bits(4)), '0, '0, rd, cnt, cw);
    check_beat({name, " read data"}, exp, rd[0]);
  endtask

  task automatic test_line(string name, adapter_cfg_pkg::addr_t base, line_t data,
                           logic [1:0] off, logic [2:0] byte_off);
    line_be_t bl;
    line_t rd;
    int cnt;
    adapter_cfg_pkg::beat_t cw;
    for (int i = 0; i < NumBeats; i++) begin
      bl[i] = '1;
      for (int b = 0; b < 8; b++) begin
        model_mem[base + 32'(i * 8 + b)] = data[i][b*8 +: 8];
      end
    end
    run_transfer({name, " write"}, 1'b1, 1'b1, base, id_t'(rand_bits(4)), data, bl,
                 rd, cnt, cw);
    run_transfer({name, " read"}, 1'b0, 1'b1, base + {27'd0, off, byte_off},
                 id_t'(rand_bits(4)), '0, '0, rd, cnt, cw);
    check_line({name, " read line"}, data, rd);
    check_bit({name, " one critical word"}, 1'b1, cnt == 1);
    check_beat({name, " critical word"}, data[off], cw);
  endtask

  initial begin
    line_t ln;
    adapter_cfg_pkg::addr_t a;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    req_i = 1'b0;
    kind_i = axi_proto_pkg::SINGLE_REQ;
    addr_i = '0;
    we_i = 1'b0;
    size_i = '0;
    id_i = '0;
    wdata_i = '0;
    be_i = '0;
    aw_ready_i = 1'b0;
    w_ready_i = 1'b0;
    b_valid_i = 1'b0;
    b_id_i = '0;
    ar_ready_i = 1'b0;
    r_valid_i = 1'b0;
    r_data_i = '0;
    r_id_i = '0;
    r_last_i = 1'b0;
    lfsr = 32'hbf6bf7bd;
    cycles = 0;
    cur_test = "reset";
    cur_line = 1'b0;
    cur_addr = '0;
    aw_seen = 1'b0;
    aw_addr_s = '0;
    aw_id_s = '0;
    w_last_seen = 1'b0;
    b_pend = 1'b0;
    b_hs = 1'b0;
    r_id_s = '0;
    r_hs = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #5;
    test_reset();
    test_single("single partial", 32'h0000_0100, 64'h1122_3344_5566_7788, 8'h0f);
    for (int i = 0; i < NumBeats; i++) begin
      ln[i] = 64'hcafe_0000_0000_0000 | 64'(i);
    end
    test_line("line basic", 32'h0000_0200, ln, 2'd2, 3'd4);
    // random mix of singles and lines
    for (int t = 0; t < 30; t++) begin
      if (next_bit()) begin
        for (int i = 0; i < NumBeats; i++) begin
          ln[i] = rand_bits(64);
        end
        a = adapter_cfg_pkg::addr_t'(rand_bits(9)) << 5;
        test_line($sformatf("random line %0d", t), a, ln, 2'(rand_bits(2)), 3'(rand_bits(3)));
      end else begin
        a = adapter_cfg_pkg::addr_t'(rand_bits(11)) << 3;
        test_single($sformatf("random single %0d", t), a, rand_bits(64), 8'(rand_bits(8)));
      end
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// File: verilog.f
adapter_cfg_pkg.sv
axi_proto_pkg.sv
engine_if.sv
adapter_dispatch.sv
axi_write_ctrl.sv
axi_read_ctrl.sv
axi_adapter.sv
tb_axi_adapter.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = tb_axi_adapter
FILELIST  = verilog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
